/* hw/alu_cfg_pkg.sv */
// ----------------------------------------------------------------------
// ALU configuration loader package
// Widths, enums and packed structs shared by the loader stages
// ----------------------------------------------------------------------

`default_nettype none

package alu_cfg_pkg;

    // ----------------------------------------------------------------------
    // Sizes
    // ----------------------------------------------------------------------
    localparam int DATA_W        = 32;
    localparam int OFFSET_W      = 16;
    localparam int SHIFT_W       = 4;
    localparam int NUM_FIELDS    = 4;
    localparam int SEQ_WINDOW    = 16;
    localparam int SLOT_W        = 4;
    localparam int IN_FIFO_DEPTH = 8;
    localparam int OUT_CREDITS   = 2;
    localparam int CRED_W        = 2;
    localparam int FIFO_PTR_W    = $clog2(IN_FIFO_DEPTH);
    localparam int FIFO_CNT_W    = FIFO_PTR_W + 1;

    typedef logic [DATA_W-1:0]                data_word_t;
    typedef logic [OFFSET_W-1:0]              offset_t;
    typedef logic [SHIFT_W-1:0]               shift_t;
    typedef logic [SLOT_W-1:0]                slot_t;
    typedef logic [NUM_FIELDS-1:0]            field_mask_t;
    typedef logic [NUM_FIELDS*NUM_FIELDS-1:0] ops_mask_t;
    typedef logic [CRED_W-1:0]                credit_t;
    typedef logic [FIFO_PTR_W-1:0]            fifo_ptr_t;
    typedef logic [FIFO_CNT_W-1:0]            fifo_cnt_t;

    // Route ids
    typedef logic [1:0] cu_id_t;
    typedef logic [1:0] bundle_id_t;
    typedef logic [1:0] lane_id_t;
    typedef logic [1:0] engine_id_t;
    typedef logic [1:0] module_id_t;
    typedef logic [2:0] buffer_id_t;

    // Slot positions of the captured fields
    localparam slot_t SLOT_OP          = 4'd0;
    localparam slot_t SLOT_ALU_MASK    = 4'd1;
    localparam slot_t SLOT_CONST_MASK  = 4'd2;
    localparam slot_t SLOT_CONST_VALUE = 4'd3;
    localparam slot_t SLOT_OPS_MASK    = 4'd4;
    localparam slot_t SLOT_ROUTE       = 4'd5;
    localparam slot_t SLOT_LAST        = slot_t'(SEQ_WINDOW - 1);

    // ----------------------------------------------------------------------
    // Enums
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        CLASS_INVALID      = 2'd0,
        CLASS_CU_SETUP     = 2'd1,
        CLASS_ENGINE_SETUP = 2'd2,
        CLASS_DATA         = 2'd3
    } buffer_class_e;

    typedef enum logic [3:0] {
        ALU_NOP = 4'd0,
        ALU_ADD = 4'd1,
        ALU_SUB = 4'd2,
        ALU_MUL = 4'd3,
        ALU_ACC = 4'd4,
        ALU_DIV = 4'd5,
        ALU_MIN = 4'd6
    } alu_op_e;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_COLLECT
    } seq_state_e;

    // ----------------------------------------------------------------------
    // Structs
    // ----------------------------------------------------------------------
    typedef struct packed {
        buffer_class_e buffer_class;
        offset_t       offset;
        shift_t        shift;
        data_word_t    data;
    } rsp_word_t;

    typedef struct packed {
        cu_id_t     id_cu;
        bundle_id_t id_bundle;
        lane_id_t   id_lane;
        engine_id_t id_engine;
        module_id_t id_module;
        buffer_id_t id_buffer;
    } cfg_route_t;

    typedef struct packed {
        alu_op_e     alu_operation;
        field_mask_t alu_mask;
        field_mask_t const_mask;
        data_word_t  const_value;
        ops_mask_t   ops_mask;
        cfg_route_t  route;
    } alu_cfg_t;

    typedef struct packed {
        slot_t      slot;
        data_word_t data;
    } slot_word_t;

endpackage

`default_nettype wire

/* hw/cfg_word_fifo.sv */
// ----------------------------------------------------------------------
// Response word FIFO
// Circular buffer that holds incoming words until decode pops them
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module cfg_word_fifo
    import alu_cfg_pkg::*;
(
    input  wire logic      ap_clk,
    input  wire logic      areset_alu_ops_generator,
    input  wire logic      push,
    input  wire rsp_word_t din,
    input  wire logic      pop,
    output rsp_word_t      dout,
    output logic           empty
);

    rsp_word_t mem [IN_FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;
    logic      full;
    logic      wr_en;
    logic      rd_en;

    assign full  = (count == fifo_cnt_t'(IN_FIFO_DEPTH));
    assign empty = (count == '0);
    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    // Head entry is always visible
    assign dout = mem[rd_ptr];

    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/cfg_word_decode.sv */
// ----------------------------------------------------------------------
// Decode stage
// Pops buffered words, filters them by class and sequence window,
// and numbers the words of one configuration sequence
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module cfg_word_decode
    import alu_cfg_pkg::*;
#(
    parameter offset_t SEQ_BASE = '0
) (
    input  wire logic      ap_clk,
    input  wire logic      areset_alu_ops_generator,
    input  wire rsp_word_t rsp,
    input  wire logic      rsp_valid,
    input  wire logic      has_credit,
    output logic           rsp_credit,
    output slot_word_t     slot_word,
    output logic           slot_valid
);

    rsp_word_t         head;
    logic              fifo_empty;
    logic              pop;
    offset_t           seq_index;
    logic [OFFSET_W:0] seq_end;
    logic              is_setup;
    logic              in_window;
    logic              take;
    seq_state_e        state;
    slot_t             next_slot;

    cfg_word_fifo u_cfg_word_fifo (
        .ap_clk                   (ap_clk),
        .areset_alu_ops_generator (areset_alu_ops_generator),
        .push                     (rsp_valid),
        .din                      (rsp),
        .pop                      (pop),
        .dout                     (head),
        .empty                    (fifo_empty)
    );

    // Stall the whole stream while downstream has no room
    assign pop = !fifo_empty && has_credit;

    // ----------------------------------------------------------------------
    // Filter
    // ----------------------------------------------------------------------
    assign seq_index = head.offset >> head.shift;
    assign seq_end   = {1'b0, SEQ_BASE} + (OFFSET_W + 1)'(SEQ_WINDOW);
    assign is_setup  = (head.buffer_class == CLASS_CU_SETUP) ||
                       (head.buffer_class == CLASS_ENGINE_SETUP);
    assign in_window = (seq_index >= SEQ_BASE) && ({1'b0, seq_index} < seq_end);

    // A sequence only opens on its base index
    assign take = pop && is_setup && in_window &&
                  ((state == SEQ_COLLECT) || (seq_index == SEQ_BASE));

    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_generator) begin
            state     <= SEQ_IDLE;
            next_slot <= '0;
        end else if (take) begin
            if (next_slot == SLOT_LAST) begin
                state     <= SEQ_IDLE;
                next_slot <= '0;
            end else begin
                state     <= SEQ_COLLECT;
                next_slot <= next_slot + 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_generator) begin
            slot_valid <= 1'b0;
            rsp_credit <= 1'b0;
        end else begin
            slot_valid <= take;
            rsp_credit <= pop;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (take) begin
            slot_word.slot <= next_slot;
            slot_word.data <= head.data;
        end
    end

endmodule

`default_nettype wire

/* hw/cfg_field_execute.sv */
// ----------------------------------------------------------------------
// Execute stage
// Writes each numbered word into its configuration fields and flags
// the last word of the sequence
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module cfg_field_execute
    import alu_cfg_pkg::*;
(
    input  wire logic       ap_clk,
    input  wire logic       areset_alu_ops_generator,
    input  wire slot_word_t slot_word,
    input  wire logic       slot_valid,
    output alu_cfg_t        cfg_next,
    output logic            cfg_done
);

    data_word_t word;

    assign word = slot_word.data;

    // ----------------------------------------------------------------------
    // Field capture
    // ----------------------------------------------------------------------
    // Fields hold their value until the same slot of a later sequence
    always_ff @(posedge ap_clk) begin
        if (slot_valid) begin
            case (slot_word.slot)
                SLOT_OP: begin
                    cfg_next.alu_operation <= alu_op_e'(word[3:0]);
                end
                SLOT_ALU_MASK: begin
                    cfg_next.alu_mask        <= word[NUM_FIELDS-1:0];
                    cfg_next.route.id_module <= word[5:4];
                    cfg_next.route.id_engine <= word[7:6];
                end
                SLOT_CONST_MASK: begin
                    cfg_next.const_mask <= word[NUM_FIELDS-1:0];
                end
                SLOT_CONST_VALUE: begin
                    cfg_next.const_value <= word;
                end
                SLOT_OPS_MASK: begin
                    cfg_next.ops_mask <= word[NUM_FIELDS*NUM_FIELDS-1:0];
                end
                SLOT_ROUTE: begin
                    cfg_next.route.id_cu     <= word[1:0];
                    cfg_next.route.id_bundle <= word[3:2];
                    cfg_next.route.id_lane   <= word[5:4];
                    cfg_next.route.id_buffer <= word[8:6];
                end
                default: begin
                    // Slots 6 to 15 carry no fields
                end
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Completion
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_generator) begin
            cfg_done <= 1'b0;
        end else begin
            cfg_done <= slot_valid && (slot_word.slot == SLOT_LAST);
        end
    end

endmodule

`default_nettype wire

/* hw/cfg_credit_result.sv */
// ----------------------------------------------------------------------
// Result stage
// Registers the finished configuration and tracks downstream credits
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module cfg_credit_result
    import alu_cfg_pkg::*;
(
    input  wire logic     ap_clk,
    input  wire logic     areset_alu_ops_generator,
    input  wire alu_cfg_t cfg_next,
    input  wire logic     cfg_done,
    input  wire logic     cfg_credit,
    output alu_cfg_t      cfg,
    output logic          cfg_valid,
    output logic          has_credit
);

    credit_t credit_count;

    // Configuration output
    always_ff @(posedge ap_clk) begin
        if (cfg_done) begin
            cfg <= cfg_next;
        end
    end

    // ----------------------------------------------------------------------
    // Send pulse and credit counter
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_generator) begin
            cfg_valid    <= 1'b0;
            credit_count <= credit_t'(OUT_CREDITS);
        end else begin
            cfg_valid <= cfg_done;
            case ({cfg_done, cfg_credit})
                2'b10:   credit_count <= credit_count - 1'b1;
                2'b01:   credit_count <= credit_count + 1'b1;
                // Send and return together cancel out
                default: credit_count <= credit_count;
            endcase
        end
    end

    // Decode keeps popping while any credit is left
    assign has_credit = (credit_count != '0);

endmodule

`default_nettype wire

/* hw/alu_ops_config_loader.sv */
// ----------------------------------------------------------------------
// ALU operation configuration loader
// Turns a window of setup response words into one ALU configuration
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module alu_ops_config_loader
    import alu_cfg_pkg::*;
#(
    parameter offset_t SEQ_BASE = '0
) (
    input  wire logic      ap_clk,
    input  wire logic      areset_alu_ops_generator,
    input  wire rsp_word_t rsp,
    input  wire logic      rsp_valid,
    output logic           rsp_credit,
    output alu_cfg_t       cfg,
    output logic           cfg_valid,
    input  wire logic      cfg_credit
);

    slot_word_t slot_word;
    logic       slot_valid;
    alu_cfg_t   cfg_next;
    logic       cfg_done;
    logic       has_credit;

    cfg_word_decode #(
        .SEQ_BASE (SEQ_BASE)
    ) u_cfg_word_decode (
        .ap_clk                   (ap_clk),
        .areset_alu_ops_generator (areset_alu_ops_generator),
        .rsp                      (rsp),
        .rsp_valid                (rsp_valid),
        .has_credit               (has_credit),
        .rsp_credit               (rsp_credit),
        .slot_word                (slot_word),
        .slot_valid               (slot_valid)
    );

    cfg_field_execute u_cfg_field_execute (
        .ap_clk                   (ap_clk),
        .areset_alu_ops_generator (areset_alu_ops_generator),
        .slot_word                (slot_word),
        .slot_valid               (slot_valid),
        .cfg_next                 (cfg_next),
        .cfg_done                 (cfg_done)
    );

    cfg_credit_result u_cfg_credit_result (
        .ap_clk                   (ap_clk),
        .areset_alu_ops_generator (areset_alu_ops_generator),
        .cfg_next                 (cfg_next),
        .cfg_done                 (cfg_done),
        .cfg_credit               (cfg_credit),
        .cfg                      (cfg),
        .cfg_valid                (cfg_valid),
        .has_credit               (has_credit)
    );

endmodule

`default_nettype wire

/* sim/tb_alu_ops_config_loader.sv */
// ----------------------------------------------------------------------
// Testbench for the ALU operation configuration loader
// Directed tests for filtering, field capture, scaled offsets and
// downstream back-pressure, with a field-rule reference model
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_alu_ops_config_loader
    import alu_cfg_pkg::*;
();

    localparam offset_t SEQ_BASE       = 16'd32;
    localparam int      TIMEOUT_CYCLES = 400;

    logic      ap_clk;
    logic      areset_alu_ops_generator;
    rsp_word_t rsp;
    logic      rsp_valid;
    logic      rsp_credit;
    alu_cfg_t  cfg;
    logic      cfg_valid;
    logic      cfg_credit;

    int         sent_count = 0;
    int         credit_count_seen = 0;
    int         cfg_count = 0;
    int         error_count = 0;
    int         check_count = 0;
    int         test_count = 0;
    alu_cfg_t   last_cfg;
    data_word_t seq_data [SEQ_WINDOW];
    integer     seed;

    alu_ops_config_loader #(
        .SEQ_BASE (SEQ_BASE)
    ) u_alu_ops_config_loader (
        .ap_clk                   (ap_clk),
        .areset_alu_ops_generator (areset_alu_ops_generator),
        .rsp                      (rsp),
        .rsp_valid                (rsp_valid),
        .rsp_credit               (rsp_credit),
        .cfg                      (cfg),
        .cfg_valid                (cfg_valid),
        .cfg_credit               (cfg_credit)
    );

    initial begin
        ap_clk = 1'b0;
        forever #50 ap_clk = ~ap_clk;
    end

    // Pulse counters and the last configuration seen downstream
    always @(posedge ap_clk) begin
        if (rsp_credit === 1'b1) begin
            credit_count_seen <= credit_count_seen + 1;
        end
        if (cfg_valid === 1'b1) begin
            cfg_count <= cfg_count + 1;
            last_cfg  <= cfg;
        end
    end

    // ----------------------------------------------------------------------
    // Checks and reporting
    // ----------------------------------------------------------------------
    task automatic compare_cfg(input string name, input alu_cfg_t got, input alu_cfg_t expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("MISMATCH %s: got %h expected %h", name, got, expected);
        end
    endtask

    task automatic compare_count(input string name, input int got, input int expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("MISMATCH %s: got %h expected %h", name, got, expected);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
    endtask

    task automatic fail_timeout(input string what);
        $display("ERROR: timed out waiting for %s", what);
        $display(">>> FAIL");
        $finish;
    endtask

    // ----------------------------------------------------------------------
    // Stimulus and reference model
    // ----------------------------------------------------------------------
    function automatic rsp_word_t make_word(input buffer_class_e cls, input offset_t off,
                                            input shift_t sh, input data_word_t data);
        rsp_word_t word;
        word.buffer_class = cls;
        word.offset       = off;
        word.shift        = sh;
        word.data         = data;
        return word;
    endfunction

    // Expected fields straight from the slot layout
    function automatic alu_cfg_t model_cfg();
        alu_cfg_t expected;
        expected                 = '0;
        expected.alu_operation   = alu_op_e'(seq_data[0][3:0]);
        expected.alu_mask        = seq_data[1][3:0];
        expected.route.id_module = seq_data[1][5:4];
        expected.route.id_engine = seq_data[1][7:6];
        expected.const_mask      = seq_data[2][3:0];
        expected.const_value     = seq_data[3];
        expected.ops_mask        = seq_data[4][15:0];
        expected.route.id_cu     = seq_data[5][1:0];
        expected.route.id_bundle = seq_data[5][3:2];
        expected.route.id_lane   = seq_data[5][5:4];
        expected.route.id_buffer = seq_data[5][8:6];
        return expected;
    endfunction

    task automatic fill_sequence();
        for (int i = 0; i < SEQ_WINDOW; i++) begin
            seq_data[i] = $random(seed);
        end
    endtask

    // Holds back while upstream has no credit left
    task automatic send_word(input rsp_word_t word);
        int waited;
        waited = 0;
        @(posedge ap_clk);
        rsp_valid <= 1'b0;
        while (sent_count - credit_count_seen >= IN_FIFO_DEPTH) begin
            if (waited >= TIMEOUT_CYCLES) begin
                fail_timeout("an upstream credit");
            end
            waited++;
            @(posedge ap_clk);
        end
        rsp       <= word;
        rsp_valid <= 1'b1;
        sent_count++;
    endtask

    task automatic end_burst();
        @(posedge ap_clk);
        rsp_valid <= 1'b0;
    endtask

    task automatic send_sequence(input buffer_class_e cls, input logic scaled);
        shift_t  sh;
        offset_t idx;
        for (int i = 0; i < SEQ_WINDOW; i++) begin
            // Scaled mode starts with offset 128 and shift 2 for index 32
            sh  = scaled ? shift_t'(2 + i % 3) : shift_t'(0);
            idx = SEQ_BASE + offset_t'(i);
            send_word(make_word(cls, idx << sh, sh, seq_data[i]));
        end
        end_burst();
    endtask

    task automatic return_cfg_credit();
        @(posedge ap_clk);
        cfg_credit <= 1'b1;
        @(posedge ap_clk);
        cfg_credit <= 1'b0;
    endtask

    task automatic wait_cfg_count(input int target);
        int waited;
        waited = 0;
        while (cfg_count < target) begin
            if (waited >= TIMEOUT_CYCLES) begin
                fail_timeout("cfg_valid");
            end
            waited++;
            @(posedge ap_clk);
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (credit_count_seen < sent_count) begin
            if (waited >= TIMEOUT_CYCLES) begin
                fail_timeout("rsp_credit for every sent word");
            end
            waited++;
            @(posedge ap_clk);
        end
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------
    task automatic quiet_after_reset();
        int errors_before;
        errors_before = error_count;
        repeat (10) @(posedge ap_clk);
        compare_count("cfg_valid pulses after reset", cfg_count, 0);
        compare_count("rsp_credit pulses after reset", credit_count_seen, 0);
        report_test("reset quiet", errors_before);
    endtask

    task automatic load_one_sequence();
        int errors_before;
        int base;
        errors_before = error_count;
        base          = cfg_count;
        fill_sequence();
        send_sequence(CLASS_ENGINE_SETUP, 1'b0);
        wait_cfg_count(base + 1);
        compare_cfg("cfg", last_cfg, model_cfg());
        repeat (10) @(posedge ap_clk);
        compare_count("cfg_valid pulses", cfg_count - base, 1);
        return_cfg_credit();
        report_test("single sequence", errors_before);
    endtask

    task automatic drop_filtered_words();
        int errors_before;
        int base_cfg;
        int base_credit;
        errors_before = error_count;
        base_cfg      = cfg_count;
        base_credit   = credit_count_seen;
        fill_sequence();
        // Data word on the base index must not open a sequence
        send_word(make_word(CLASS_DATA, SEQ_BASE, '0, $random(seed)));
        for (int i = 0; i < SEQ_WINDOW; i++) begin
            if (i == 1) begin
                // Rejected words inside an open sequence take no slot
                send_word(make_word(CLASS_ENGINE_SETUP, SEQ_BASE - 16'd1, '0, $random(seed)));
                send_word(make_word(CLASS_CU_SETUP, SEQ_BASE + 16'd16, '0, $random(seed)));
                send_word(make_word(CLASS_DATA, SEQ_BASE + 16'd8, '0, $random(seed)));
            end
            send_word(make_word(CLASS_ENGINE_SETUP, SEQ_BASE + offset_t'(i), '0, seq_data[i]));
        end
        end_burst();
        wait_cfg_count(base_cfg + 1);
        compare_cfg("cfg", last_cfg, model_cfg());
        wait_drained();
        repeat (10) @(posedge ap_clk);
        compare_count("cfg_valid pulses", cfg_count - base_cfg, 1);
        compare_count("rsp_credit pulses", credit_count_seen - base_credit, SEQ_WINDOW + 4);
        return_cfg_credit();
        report_test("filtered words", errors_before);
    endtask

    task automatic index_scaled_offsets();
        int errors_before;
        int base;
        errors_before = error_count;
        base          = cfg_count;
        fill_sequence();
        send_sequence(CLASS_CU_SETUP, 1'b1);
        wait_cfg_count(base + 1);
        compare_cfg("cfg", last_cfg, model_cfg());
        return_cfg_credit();
        report_test("scaled offsets", errors_before);
    endtask

    task automatic stall_without_credit();
        int       errors_before;
        int       base;
        int       waited;
        alu_cfg_t third_expected;
        errors_before = error_count;
        base          = cfg_count;
        fill_sequence();
        send_sequence(CLASS_ENGINE_SETUP, 1'b0);
        wait_cfg_count(base + 1);
        compare_cfg("cfg first", last_cfg, model_cfg());
        fill_sequence();
        send_sequence(CLASS_CU_SETUP, 1'b0);
        wait_cfg_count(base + 2);
        compare_cfg("cfg second", last_cfg, model_cfg());
        fill_sequence();
        third_expected = model_cfg();
        fork
            send_sequence(CLASS_ENGINE_SETUP, 1'b0);
            begin
                // Input buffer full while no configuration credit is left
                waited = 0;
                while (sent_count - credit_count_seen < IN_FIFO_DEPTH) begin
                    if (waited >= TIMEOUT_CYCLES) begin
                        fail_timeout("the input buffer to fill");
                    end
                    waited++;
                    @(posedge ap_clk);
                end
                compare_count("cfg_valid pulses while stalled", cfg_count - base, 2);
                return_cfg_credit();
            end
        join
        wait_cfg_count(base + 3);
        compare_cfg("cfg third", last_cfg, third_expected);
        return_cfg_credit();
        return_cfg_credit();
        report_test("back-pressure", errors_before);
    endtask

    task automatic match_credit_total();
        int errors_before;
        errors_before = error_count;
        wait_drained();
        repeat (10) @(posedge ap_clk);
        compare_count("rsp_credit total", credit_count_seen, sent_count);
        report_test("credit total", errors_before);
    endtask

    initial begin
        seed                     = 32'h89d4caba;
        rsp                      = '0;
        rsp_valid                = 1'b0;
        cfg_credit               = 1'b0;
        areset_alu_ops_generator = 1'b1;
        repeat (3) @(posedge ap_clk);
        areset_alu_ops_generator <= 1'b0;

        quiet_after_reset();
        load_one_sequence();
        drop_filtered_words();
        index_scaled_offsets();
        stall_without_credit();
        match_credit_total();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/alu_cfg_pkg.sv
hw/cfg_word_fifo.sv
hw/cfg_word_decode.sv
hw/cfg_field_execute.sv
hw/cfg_credit_result.sv
hw/alu_ops_config_loader.sv
sim/tb_alu_ops_config_loader.sv

/* Bender.yml */
package:
  name: alu_ops_config_loader

sources:
  - files:
      - hw/alu_cfg_pkg.sv
      - hw/cfg_word_fifo.sv
      - hw/cfg_word_decode.sv
      - hw/cfg_field_execute.sv
      - hw/cfg_credit_result.sv
      - hw/alu_ops_config_loader.sv
  - target: simulation
    files:
      - sim/tb_alu_ops_config_loader.sv
